//--- logic/decodePkg.sv
`default_nettype none

package decodePkg;

	////////////////////////////// widths
	localparam int INSTR_WIDTH = 32;
	localparam int OPCODE_WIDTH = 6;
	localparam int REG_WIDTH = 5;
	localparam int IMM_WIDTH = 16;
	localparam int IMM_EXT_WIDTH = 64;
	localparam int SHIFT_WIDTH = 2;
	localparam int DS_XO_WIDTH = 2;

	// field bounds, ISA numbering (bit 0 is the msb)
	localparam int OPCODE_LO = 0;
	localparam int OPCODE_HI = 5;
	localparam int REG1_LO = 6;
	localparam int REG2_LO = 11;
	localparam int IMM_LO = 16;
	localparam int DS_XO_LO = 30;

	typedef logic [0:INSTR_WIDTH-1] instrT;
	typedef logic [0:OPCODE_WIDTH-1] opcodeT;
	typedef logic [0:REG_WIDTH-1] regAddrT;
	typedef logic [0:IMM_WIDTH-1] immT;
	typedef logic [0:IMM_EXT_WIDTH-1] immExtT;
	typedef logic [0:SHIFT_WIDTH-1] shiftBytesT; // 0 none, 2 up 16 bits, 3 up 32 bits
	typedef logic [0:DS_XO_WIDTH-1] dsXoT;

	typedef enum logic [1:0] {formNone, formD, formDs} formatT;

	localparam logic IMM_SIGNED = 1'b1;
	localparam logic IMM_UNSIGNED = 1'b0;

	localparam shiftBytesT SHIFT_NONE = 2'd0;
	localparam shiftBytesT SHIFT_2B = 2'd2;
	localparam shiftBytesT SHIFT_4B = 2'd3; // 4 bytes does not fit, coded as 3

	////////////////////////////// fixed point D form
	localparam opcodeT OP_TDI = 6'd2;
	localparam opcodeT OP_TWI = 6'd3;
	localparam opcodeT OP_MULLI = 6'd7;
	localparam opcodeT OP_SUBFIC = 6'd8;
	localparam opcodeT OP_CMPLI = 6'd10;
	localparam opcodeT OP_CMPI = 6'd11;
	localparam opcodeT OP_ADDIC = 6'd12;
	localparam opcodeT OP_ADDIC_RC = 6'd13;
	localparam opcodeT OP_ADDI = 6'd14;
	localparam opcodeT OP_ADDIS = 6'd15;
	localparam opcodeT OP_ORI = 6'd24;
	localparam opcodeT OP_ORIS = 6'd25;
	localparam opcodeT OP_XORI = 6'd26;
	localparam opcodeT OP_XORIS = 6'd27;
	localparam opcodeT OP_ANDI_RC = 6'd28;
	localparam opcodeT OP_ANDIS_RC = 6'd29;
	localparam opcodeT OP_LWZ = 6'd32;
	localparam opcodeT OP_LWZU = 6'd33;
	localparam opcodeT OP_LBZ = 6'd34;
	localparam opcodeT OP_LBZU = 6'd35;
	localparam opcodeT OP_STW = 6'd36;
	localparam opcodeT OP_STWU = 6'd37;
	localparam opcodeT OP_STB = 6'd38;
	localparam opcodeT OP_STBU = 6'd39;
	localparam opcodeT OP_LHZ = 6'd40;
	localparam opcodeT OP_LHZU = 6'd41;
	localparam opcodeT OP_LHA = 6'd42;
	localparam opcodeT OP_LHAU = 6'd43;
	localparam opcodeT OP_STH = 6'd44;
	localparam opcodeT OP_STHU = 6'd45;
	localparam opcodeT OP_LMW = 6'd46;
	localparam opcodeT OP_STMW = 6'd47;

	// floating point D form
	localparam opcodeT OP_LFS = 6'd48;
	localparam opcodeT OP_LFSU = 6'd49;
	localparam opcodeT OP_LFD = 6'd50;
	localparam opcodeT OP_LFDU = 6'd51;
	localparam opcodeT OP_STFS = 6'd52;
	localparam opcodeT OP_STFSU = 6'd53;
	localparam opcodeT OP_STFD = 6'd54;
	localparam opcodeT OP_STFDU = 6'd55;

	////////////////////////////// DS form
	localparam opcodeT OP_LD_GROUP = 6'd58;
	localparam opcodeT OP_STD_GROUP = 6'd62;
	localparam dsXoT DS_XO_LD = 2'd0;
	localparam dsXoT DS_XO_LDU = 2'd1;
	localparam dsXoT DS_XO_LWA = 2'd2;
	localparam dsXoT DS_XO_STD = 2'd0;
	localparam dsXoT DS_XO_STDU = 2'd1;

endpackage

`default_nettype wire

//--- logic/immExtender.sv
`timescale 1ns/10ps
`default_nettype none

module immExtender (
	input wire decodePkg::immT imm_i,
	input wire logic immFormat_i,
	input wire decodePkg::shiftBytesT shiftImmUpBytes_i,
	output decodePkg::immExtT immExt_o
);

	import decodePkg::*;

	localparam int PAD_WIDTH = IMM_EXT_WIDTH - IMM_WIDTH;

	immExtT extended;

	// sign bit is bit 0 in ISA numbering
	always_comb begin
		if (immFormat_i == IMM_SIGNED) begin
			extended = {{PAD_WIDTH{imm_i[0]}}, imm_i};
		end else begin
			extended = {{PAD_WIDTH{1'b0}}, imm_i};
		end
	end

	// shift moves toward bit 0, the msb
	always_comb begin
		case (shiftImmUpBytes_i)
			SHIFT_2B: immExt_o = extended << 16;
			SHIFT_4B: immExt_o = extended << 32;
			default: immExt_o = extended; // none, code 1 unused
		endcase
	end

endmodule

`default_nettype wire

//--- logic/dFormatDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module dFormatDecoder (
	input wire logic clock_i,
	input wire logic arstN_i,
	input wire logic enable_i,
	input wire decodePkg::instrT instruction_i,
	output decodePkg::regAddrT reg1_o,
	output decodePkg::regAddrT reg2_o,
	output logic reg2ValOrZero_o, // RA of zero means literal zero, not r0
	output decodePkg::immT imm_o,
	output logic immFormat_o,
	output decodePkg::shiftBytesT shiftImmUpBytes_o,
	output logic hit_o
);

	import decodePkg::*;

	opcodeT opcode;
	logic hitNext;
	logic reg2ZeroNext;
	logic immFormatNext;
	shiftBytesT shiftNext;

	assign opcode = instruction_i[OPCODE_LO:OPCODE_HI];

	//////////////////////////////
	// opcode table
	always_comb begin
		hitNext = 1'b0;
		reg2ZeroNext = 1'b0;
		immFormatNext = IMM_SIGNED;
		shiftNext = SHIFT_NONE;
		case (opcode)
			// non-update loads and stores use (RA|0)
			OP_LWZ, OP_LBZ, OP_LHZ, OP_LHA,
			OP_STW, OP_STB, OP_STH,
			OP_LMW, OP_STMW,
			OP_LFS, OP_LFD, OP_STFS, OP_STFD: begin
				hitNext = 1'b1;
				reg2ZeroNext = 1'b1;
			end
			OP_ADDI: begin
				hitNext = 1'b1;
				reg2ZeroNext = 1'b1;
			end
			// update forms write RA back, so RA is a real register
			OP_LWZU, OP_LBZU, OP_LHZU, OP_LHAU,
			OP_STWU, OP_STBU, OP_STHU,
			OP_LFSU, OP_LFDU, OP_STFSU, OP_STFDU: begin
				hitNext = 1'b1;
			end
			// signed arithmetic, compare and trap
			OP_ADDIC, OP_ADDIC_RC, OP_SUBFIC, OP_MULLI,
			OP_CMPI, OP_TWI, OP_TDI: begin
				hitNext = 1'b1;
			end
			OP_ADDIS: begin
				hitNext = 1'b1;
				shiftNext = SHIFT_2B; // imm lands in bits 32..47
			end
			OP_CMPLI, OP_ORI, OP_XORI, OP_ANDI_RC: begin
				hitNext = 1'b1;
				immFormatNext = IMM_UNSIGNED;
			end
			OP_ORIS, OP_XORIS, OP_ANDIS_RC: begin
				hitNext = 1'b1;
				immFormatNext = IMM_UNSIGNED;
				shiftNext = SHIFT_2B;
			end
			default: begin
				immFormatNext = IMM_UNSIGNED; // not ours, clear controls
			end
		endcase
	end

	//////////////////////////////
	// registers
	always_ff @(posedge clock_i or negedge arstN_i) begin
		if (!arstN_i) begin
			hit_o <= 1'b0;
		end else begin
			hit_o <= enable_i & hitNext; // drops on idle cycles
		end
	end

	always_ff @(posedge clock_i) begin
		if (enable_i) begin
			reg1_o <= instruction_i[REG1_LO +: REG_WIDTH];
			reg2_o <= instruction_i[REG2_LO +: REG_WIDTH];
			imm_o <= instruction_i[IMM_LO +: IMM_WIDTH];
			reg2ValOrZero_o <= reg2ZeroNext;
			immFormat_o <= immFormatNext;
			shiftImmUpBytes_o <= shiftNext;
		end
	end

endmodule

`default_nettype wire

//--- logic/dsFormatDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module dsFormatDecoder (
	input wire logic clock_i,
	input wire logic arstN_i,
	input wire logic enable_i,
	input wire decodePkg::instrT instruction_i,
	output decodePkg::regAddrT reg1_o,
	output decodePkg::regAddrT reg2_o,
	output logic reg2ValOrZero_o,
	output decodePkg::immT imm_o,
	output logic immFormat_o,
	output decodePkg::shiftBytesT shiftImmUpBytes_o,
	output logic hit_o
);

	import decodePkg::*;

	opcodeT opcode;
	dsXoT xo;
	logic hitNext;
	logic reg2ZeroNext;

	assign opcode = instruction_i[OPCODE_LO:OPCODE_HI];
	assign xo = instruction_i[DS_XO_LO +: DS_XO_WIDTH];

	// only ld, ldu, lwa, std and stdu are claimed
	always_comb begin
		hitNext = 1'b0;
		reg2ZeroNext = 1'b0;
		case (opcode)
			OP_LD_GROUP: begin
				hitNext = (xo == DS_XO_LD) || (xo == DS_XO_LDU) || (xo == DS_XO_LWA);
				reg2ZeroNext = (xo == DS_XO_LD) || (xo == DS_XO_LWA);
			end
			OP_STD_GROUP: begin
				hitNext = (xo == DS_XO_STD) || (xo == DS_XO_STDU);
				reg2ZeroNext = (xo == DS_XO_STD);
			end
			default: hitNext = 1'b0;
		endcase
	end

	always_ff @(posedge clock_i or negedge arstN_i) begin
		if (!arstN_i) begin
			hit_o <= 1'b0;
		end else begin
			hit_o <= enable_i & hitNext;
		end
	end

	always_ff @(posedge clock_i) begin
		if (enable_i) begin
			reg1_o <= instruction_i[REG1_LO +: REG_WIDTH];
			reg2_o <= instruction_i[REG2_LO +: REG_WIDTH];
			imm_o <= {instruction_i[IMM_LO:DS_XO_LO-1], 2'b00}; // DS field is a word offset
			reg2ValOrZero_o <= reg2ZeroNext;
			immFormat_o <= IMM_SIGNED;
			shiftImmUpBytes_o <= SHIFT_NONE;
		end
	end

endmodule

`default_nettype wire

//--- logic/decodeSelect.sv
`timescale 1ns/10ps
`default_nettype none

module decodeSelect (
	input wire logic clock_i,
	input wire logic arstN_i,
	input wire logic enable_i,
	input wire logic dHit_i,
	input wire logic dsHit_i,
	input wire decodePkg::regAddrT dReg1_i,
	input wire decodePkg::regAddrT dReg2_i,
	input wire decodePkg::regAddrT dsReg1_i,
	input wire decodePkg::regAddrT dsReg2_i,
	input wire logic dReg2Zero_i,
	input wire logic dsReg2Zero_i,
	input wire logic dImmFormat_i,
	input wire logic dsImmFormat_i,
	input wire decodePkg::immT dImm_i,
	input wire decodePkg::immT dsImm_i,
	input wire decodePkg::shiftBytesT dShift_i,
	input wire decodePkg::shiftBytesT dsShift_i,
	output logic valid_o,
	output logic illegal_o,
	output decodePkg::formatT format_o,
	output decodePkg::regAddrT reg1_o,
	output decodePkg::regAddrT reg2_o,
	output logic reg2ValOrZero_o,
	output decodePkg::immExtT immExt_o
);

	import decodePkg::*;

	logic stage1Valid; // an instruction sits in the decoder registers
	logic anyHit;
	immT selImm;
	logic selImmFormat;
	shiftBytesT selShift;
	immExtT selImmExt;

	assign anyHit = dHit_i | dsHit_i;

	// opcode sets are disjoint, at most one decoder hits
	assign selImm = dHit_i ? dImm_i : dsImm_i;
	assign selImmFormat = dHit_i ? dImmFormat_i : dsImmFormat_i;
	assign selShift = dHit_i ? dShift_i : dsShift_i;

	immExtender extender (
		.imm_i(selImm),
		.immFormat_i(selImmFormat),
		.shiftImmUpBytes_i(selShift),
		.immExt_o(selImmExt)
	);

	always_ff @(posedge clock_i or negedge arstN_i) begin
		if (!arstN_i) begin
			stage1Valid <= 1'b0;
			valid_o <= 1'b0;
			illegal_o <= 1'b0;
			format_o <= formNone;
		end else begin
			stage1Valid <= enable_i;
			valid_o <= stage1Valid & anyHit;
			illegal_o <= stage1Valid & ~anyHit; // nobody claimed it
			if (stage1Valid && anyHit) begin
				format_o <= dHit_i ? formD : formDs;
			end
		end
	end

	// data holds through illegal and idle cycles
	always_ff @(posedge clock_i) begin
		if (stage1Valid && anyHit) begin
			reg1_o <= dHit_i ? dReg1_i : dsReg1_i;
			reg2_o <= dHit_i ? dReg2_i : dsReg2_i;
			reg2ValOrZero_o <= dHit_i ? dReg2Zero_i : dsReg2Zero_i;
			immExt_o <= selImmExt;
		end
	end

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
	input wire logic clock_i,
	input wire logic arstN_i,
	input wire logic enable_i,
	input wire decodePkg::instrT instruction_i,
	output logic valid_o,
	output logic illegal_o,
	output decodePkg::formatT format_o,
	output decodePkg::regAddrT reg1_o,
	output decodePkg::regAddrT reg2_o,
	output logic reg2ValOrZero_o,
	output decodePkg::immExtT immExt_o
);

	import decodePkg::*;

	////////////////////////////// stage 1 results
	logic dHit, dsHit;
	regAddrT dReg1, dReg2, dsReg1, dsReg2;
	logic dReg2Zero, dsReg2Zero;
	logic dImmFormat, dsImmFormat;
	immT dImm, dsImm;
	shiftBytesT dShift, dsShift;

	dFormatDecoder dDecoder (
		.clock_i(clock_i),
		.arstN_i(arstN_i),
		.enable_i(enable_i),
		.instruction_i(instruction_i),
		.reg1_o(dReg1),
		.reg2_o(dReg2),
		.reg2ValOrZero_o(dReg2Zero),
		.imm_o(dImm),
		.immFormat_o(dImmFormat),
		.shiftImmUpBytes_o(dShift),
		.hit_o(dHit)
	);

	dsFormatDecoder dsDecoder (
		.clock_i(clock_i),
		.arstN_i(arstN_i),
		.enable_i(enable_i),
		.instruction_i(instruction_i),
		.reg1_o(dsReg1),
		.reg2_o(dsReg2),
		.reg2ValOrZero_o(dsReg2Zero),
		.imm_o(dsImm),
		.immFormat_o(dsImmFormat),
		.shiftImmUpBytes_o(dsShift),
		.hit_o(dsHit)
	);

	////////////////////////////// stage 2
	decodeSelect select (
		.clock_i(clock_i),
		.arstN_i(arstN_i),
		.enable_i(enable_i),
		.dHit_i(dHit),
		.dsHit_i(dsHit),
		.dReg1_i(dReg1),
		.dReg2_i(dReg2),
		.dsReg1_i(dsReg1),
		.dsReg2_i(dsReg2),
		.dReg2Zero_i(dReg2Zero),
		.dsReg2Zero_i(dsReg2Zero),
		.dImmFormat_i(dImmFormat),
		.dsImmFormat_i(dsImmFormat),
		.dImm_i(dImm),
		.dsImm_i(dsImm),
		.dShift_i(dShift),
		.dsShift_i(dsShift),
		.valid_o(valid_o),
		.illegal_o(illegal_o),
		.format_o(format_o),
		.reg1_o(reg1_o),
		.reg2_o(reg2_o),
		.reg2ValOrZero_o(reg2ValOrZero_o),
		.immExt_o(immExt_o)
	);

endmodule

`default_nettype wire

//--- verification/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH
`default_nettype none

// expected decode of one instruction word
typedef struct packed {
	logic legal;
	decodePkg::formatT format;
	decodePkg::regAddrT reg1;
	decodePkg::regAddrT reg2;
	logic reg2Zero; // RA field means literal zero when it is 0
	decodePkg::immExtT imm;
} expectT;

function automatic expectT decodeExpected(input decodePkg::instrT instr);
	expectT e;
	logic [5:0] op;
	logic [1:0] xo;
	logic [15:0] imm16;
	logic [63:0] ext;
	logic zeroExtend;
	logic shiftUp;
	op = instr[0:5];
	xo = instr[30:31];
	e.legal = 1'b1;
	e.format = decodePkg::formD;
	e.reg1 = instr[6:10];
	e.reg2 = instr[11:15];
	e.reg2Zero = 1'b0;
	zeroExtend = 1'b0;
	shiftUp = 1'b0;
	case (op)
		// loads and stores without update, lmw, stmw, addi
		6'd32, 6'd34, 6'd36, 6'd38, 6'd40, 6'd42, 6'd44, 6'd46, 6'd47,
		6'd48, 6'd50, 6'd52, 6'd54, 6'd14: e.reg2Zero = 1'b1;
		// update forms, then trap, mulli, subfic, cmpi, addic
		6'd33, 6'd35, 6'd37, 6'd39, 6'd41, 6'd43, 6'd45,
		6'd49, 6'd51, 6'd53, 6'd55,
		6'd2, 6'd3, 6'd7, 6'd8, 6'd11, 6'd12, 6'd13: e.reg2Zero = 1'b0;
		6'd15: shiftUp = 1'b1; // addis
		6'd10, 6'd24, 6'd26, 6'd28: zeroExtend = 1'b1; // cmpli and logical
		6'd25, 6'd27, 6'd29: begin
			zeroExtend = 1'b1;
			shiftUp = 1'b1;
		end
		6'd58: begin // ld, ldu, lwa
			e.format = decodePkg::formDs;
			e.legal = (xo != 2'd3);
			e.reg2Zero = (xo == 2'd0) || (xo == 2'd2);
		end
		6'd62: begin // std, stdu
			e.format = decodePkg::formDs;
			e.legal = (xo == 2'd0) || (xo == 2'd1);
			e.reg2Zero = (xo == 2'd0);
		end
		default: e.legal = 1'b0;
	endcase

	// DS offset is a word count, low two bits are zero
	if (e.format == decodePkg::formDs) begin
		imm16 = {instr[16:29], 2'b00};
	end else begin
		imm16 = instr[16:31];
	end
	if (zeroExtend) begin
		ext = {48'h0, imm16};
	end else begin
		ext = {{48{imm16[15]}}, imm16};
	end
	if (shiftUp) begin
		ext = ext << 16;
	end
	e.imm = ext;
	if (!e.legal) begin
		e.format = decodePkg::formNone;
	end
	return e;
endfunction

`default_nettype wire
`endif

//--- verification/decodeStageTb.sv
`timescale 1ns/10ps
`include "decodeModel.svh"
`default_nettype none

module decodeStageTb;

	import decodePkg::*;

	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 4;
	localparam int IDLE_GAP = 4;
	localparam int N_D_OPS = 40;
	localparam int N_RANDOM = 300;
	localparam int N_DIRECTED = N_D_OPS + 4 + 7 + 4 + 10; // D, extension, DS, illegal, reset
	localparam int STIM_CYCLES = 2 * RESET_CYCLES + N_DIRECTED + N_RANDOM + 10 * IDLE_GAP + 3;
	localparam int LATENCY_EDGES = 3; // drive edge, decoder stage, select stage

	logic clock, arstN, enable, valid, illegal, reg2ValOrZero;
	instrT instruction;
	formatT format;
	regAddrT reg1, reg2;
	immExtT immExt;

	integer seed;
	int cycleCount = 0;
	int errors = 0;
	int checked = 0;
	int lostResults;
	expectT expectedQ[$];
	int issueQ[$]; // cycle of each drive edge, same order as expectedQ

	// the 40 D-form opcodes first, then the two DS groups
	opcodeT legalOps[$] = '{6'd2, 6'd3, 6'd7, 6'd8, 6'd10, 6'd11, 6'd12, 6'd13, 6'd14, 6'd15,
		6'd24, 6'd25, 6'd26, 6'd27, 6'd28, 6'd29, 6'd32, 6'd33, 6'd34, 6'd35, 6'd36, 6'd37,
		6'd38, 6'd39, 6'd40, 6'd41, 6'd42, 6'd43, 6'd44, 6'd45, 6'd46, 6'd47, 6'd48, 6'd49,
		6'd50, 6'd51, 6'd52, 6'd53, 6'd54, 6'd55, 6'd58, 6'd62};

	decodeStage dut0 (
		.clock_i(clock),
		.arstN_i(arstN),
		.enable_i(enable),
		.instruction_i(instruction),
		.valid_o(valid),
		.illegal_o(illegal),
		.format_o(format),
		.reg1_o(reg1),
		.reg2_o(reg2),
		.reg2ValOrZero_o(reg2ValOrZero),
		.immExt_o(immExt)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock) cycleCount <= cycleCount + 1;

	////////////////////////////// stimulus helpers
	function automatic instrT opWord(input opcodeT op);
		instrT word;
		word = $random(seed); // random register and immediate fields
		word[OPCODE_LO:OPCODE_HI] = op;
		return word;
	endfunction

	function automatic instrT dsWord(input opcodeT op, input logic [1:0] xo);
		instrT word;
		word = opWord(op);
		word[30:31] = xo;
		return word;
	endfunction

	// three in four draw a legal opcode
	function automatic instrT randomWord();
		int pick;
		pick = $unsigned($random(seed)) % legalOps.size();
		if ($unsigned($random(seed)) % 4 != 0) begin
			return opWord(legalOps[pick]);
		end else begin
			return $random(seed);
		end
	endfunction

	task automatic issue(input instrT word);
		@(posedge clock);
		enable <= 1'b1;
		instruction <= word;
		expectedQ.push_back(decodeExpected(word));
		issueQ.push_back(cycleCount);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			enable <= 1'b0;
		end
	endtask

	////////////////////////////// checking
	task automatic reportMismatch(input string name, input logic [63:0] got,
			input logic [63:0] want);
		errors++;
		$display("CHECK FAILED %s got %h expected %h at %0t", name, got, want, $time);
	endtask

	task automatic compareResult(input expectT exp, input int issuedAt);
		int latency;
		latency = cycleCount - issuedAt;
		checked++;
		if (latency != LATENCY_EDGES) begin
			errors++;
			$display("result arrived %0d cycles after its drive edge instead of %0d",
				latency, LATENCY_EDGES);
		end
		if (exp.legal) begin
			if (valid !== 1'b1) reportMismatch("valid_o", 64'(valid), 64'(1'b1));
			if (illegal !== 1'b0) reportMismatch("illegal_o", 64'(illegal), 64'(1'b0));
			if (format !== exp.format) reportMismatch("format_o", 64'(format), 64'(exp.format));
			if (reg1 !== exp.reg1) reportMismatch("reg1_o", 64'(reg1), 64'(exp.reg1));
			if (reg2 !== exp.reg2) reportMismatch("reg2_o", 64'(reg2), 64'(exp.reg2));
			if (reg2ValOrZero !== exp.reg2Zero) begin
				reportMismatch("reg2ValOrZero_o", 64'(reg2ValOrZero), 64'(exp.reg2Zero));
			end
			if (immExt !== exp.imm) reportMismatch("immExt_o", 64'(immExt), 64'(exp.imm));
		end else begin
			if (illegal !== 1'b1) reportMismatch("illegal_o", 64'(illegal), 64'(1'b1));
			if (valid !== 1'b0) reportMismatch("valid_o", 64'(valid), 64'(1'b0));
		end
	endtask

	// outputs are sampled mid-cycle
	always @(negedge clock) begin
		if (!arstN) begin
			if (valid === 1'b1 || illegal === 1'b1) begin
				errors++;
				$display("valid or illegal is high while reset is asserted at %0t", $time);
			end
			expectedQ.delete(); // in-flight instructions are lost
			issueQ.delete();
		end else if (valid === 1'b1 || illegal === 1'b1) begin
			if (expectedQ.size() == 0) begin
				errors++;
				$display("result pulse with no instruction outstanding at %0t", $time);
			end else begin
				compareResult(expectedQ.pop_front(), issueQ.pop_front());
			end
		end
	end

	////////////////////////////// test sequence
	initial begin
		seed = 32'h2d70_4659;
		arstN = 1'b0;
		enable = 1'b0;
		instruction = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		arstN <= 1'b1;
		idle(2);

		for (int i = 0; i < N_D_OPS; i++) begin
			issue(opWord(legalOps[i]));
		end
		idle(IDLE_GAP);

		// sign and zero extension, with and without the 16-bit shift
		issue({OP_ADDI, 5'd3, 5'd0, 16'h8000});
		issue({OP_CMPLI, 5'd1, 5'd4, 16'h8000});
		issue({OP_ADDIS, 5'd9, 5'd2, 16'h8001});
		issue({OP_ANDIS_RC, 5'd7, 5'd8, 16'hf00f});
		idle(IDLE_GAP);

		for (int i = 0; i < 4; i++) begin
			issue(dsWord(OP_LD_GROUP, 2'(i))); // xo 3 is not claimed
		end
		for (int i = 0; i < 3; i++) begin
			issue(dsWord(OP_STD_GROUP, 2'(i))); // xo 2 is not claimed
		end
		idle(IDLE_GAP);

		issue(opWord(6'd31));
		issue(opWord(6'd19));
		issue(opWord(6'd0));
		issue(opWord(6'd63));
		idle(IDLE_GAP);

		for (int i = 0; i < N_RANDOM; i++) begin
			issue(randomWord());
		end
		idle(3 * IDLE_GAP);

		// reset lands with two instructions still in the pipe
		for (int i = 0; i < 6; i++) begin
			issue(randomWord());
		end
		@(posedge clock);
		enable <= 1'b0;
		arstN <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		arstN <= 1'b1;
		idle(IDLE_GAP);
		for (int i = 0; i < 4; i++) begin
			issue(randomWord());
		end
		idle(2 * IDLE_GAP);

		lostResults = expectedQ.size();
		if (lostResults != 0) begin
			$display("%0d expected results never arrived", lostResults);
		end
		$display("results checked %0d, errors %0d, missing results %0d",
			checked, errors, lostResults);
		if (errors == 0 && lostResults == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#((STIM_CYCLES + 20) * CLOCK_PERIOD);
		$display("watchdog expired after %0d cycles before the test sequence ended",
			STIM_CYCLES + 20);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+verification
logic/decodePkg.sv
logic/immExtender.sv
logic/dFormatDecoder.sv
logic/dsFormatDecoder.sv
logic/decodeSelect.sv
logic/decodeStage.sv
verification/decodeStageTb.sv

//--- Makefile
# Verilator simulation of the decode slice

VERILATOR ?= verilator
TOP ?= decodeStageTb
FILELIST ?= files.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
